// File: all.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipe_control.sv
rtl/core_top.sv
+incdir+testbench
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_core -o tb_core_sim

./obj_dir/tb_core_sim | tee sim.log

grep -q '^\*\* PASS \*\*$' sim.log

// File: testbench/tb_ref_model.svh
// Instruction-level model of the core, run once in program order per test run.
// Fills the expected writeback queues, the load-use count and the final data memory.

function automatic void build_expected();
    word_t      regs [32];
    word_t      inst;
    word_t      pc;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      simm;
    word_t      zimm;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] sh;
    logic       wr;
    logic       reads_rs;
    logic       reads_rt;
    int         dest;
    int         last_load;

    exp_pc.delete();
    exp_rd.delete();
    exp_val.delete();
    exp_interlocks = 0;
    last_load      = 0;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
        exp_ram[i] = ram_fill(i);
    end

    for (int i = 0; i < PROG_LEN; i++) begin
        inst     = prog[i];
        pc       = RESET_PC + word_t'(4 * i);
        op       = inst[31:26];
        fn       = inst[5:0];
        sh       = inst[10:6];
        a        = regs[inst[25:21]];
        b        = regs[inst[20:16]];
        simm     = {{16{inst[15]}}, inst[15:0]};
        zimm     = {16'h0000, inst[15:0]};
        addr     = a + simm;
        wr       = 1'b1;
        reads_rs = 1'b1;
        reads_rt = 1'b0;
        dest     = int'(inst[20:16]);
        res      = '0;
        case (op)
            6'h00: begin
                dest     = int'(inst[15:11]);
                reads_rt = 1'b1;
                case (fn)
                    6'h00: begin
                        res      = b << sh;
                        reads_rs = 1'b0;
                    end
                    6'h02: begin
                        res      = b >> sh;
                        reads_rs = 1'b0;
                    end
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2A: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2B: res = (a < b) ? 32'd1 : 32'd0;
                    default: begin
                        wr       = 1'b0;
                        reads_rs = 1'b0;
                        reads_rt = 1'b0;
                    end
                endcase
            end
            6'h09: res = a + simm;
            6'h0A: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            6'h0C: res = a & zimm;
            6'h0D: res = a | zimm;
            6'h0E: res = a ^ zimm;
            6'h0F: begin
                res      = {inst[15:0], 16'h0000};
                reads_rs = 1'b0;
            end
            6'h23: res = exp_ram[addr[9:2]];
            6'h2B: begin
                exp_ram[addr[9:2]] = b;
                wr       = 1'b0;
                reads_rt = 1'b1;
            end
            default: begin
                wr       = 1'b0;
                reads_rs = 1'b0;
            end
        endcase
        // A reader right behind a load waits one cycle
        if (last_load != 0 && ((reads_rs && int'(inst[25:21]) == last_load)
                || (reads_rt && int'(inst[20:16]) == last_load))) begin
            exp_interlocks++;
        end
        last_load = (op == 6'h23) ? dest : 0;
        // Register 0 is never written
        if (wr && dest != 0) begin
            regs[dest] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(reg_addr_t'(dest));
            exp_val.push_back(res);
        end
    end
endfunction

// File: testbench/tb_core.sv
// Testbench for core_top: bus memory models, a fixed program, trace and memory checks.
// Runs the program twice, first without and then with random bus stalls.
`timescale 1ns/1ns

module tb_core;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam word_t RESET_PC  = 32'hBFC0_0000;
    localparam int    PROG_LEN  = 32;
    localparam int    RAM_WORDS = 256;
    localparam int    LIMIT     = PROG_LEN * 20 + 200;

    logic      clk;
    logic      arst_n_i;
    logic      ibus_en_o;
    word_t     ibus_addr_o;
    word_t     ibus_rdata_i;
    logic      ibus_streq_i;
    logic      ibus_stall_o;
    logic      dbus_en_o;
    word_t     dbus_addr_o;
    byte_en_t  dbus_wen_o;
    word_t     dbus_wdata_o;
    word_t     dbus_rdata_i;
    logic      dbus_streq_i;
    logic      dbus_stall_o;
    word_t     debug_wb_pc_o;
    byte_en_t  debug_wb_wen_o;
    reg_addr_t debug_wb_wraddr_o;
    word_t     debug_wb_wrdata_o;

    word_t     prog    [PROG_LEN];
    word_t     ram     [RAM_WORDS];
    word_t     exp_ram [RAM_WORDS];
    word_t     exp_pc  [$];
    reg_addr_t exp_rd  [$];
    word_t     exp_val [$];
    int        exp_interlocks;
    int        interlocks;

    integer    seed;
    int        errors;
    int        cycle_cnt;
    logic      cnt_clear;
    logic      stalls_on;
    int        istall_left;
    int        dstall_left;

    // Initial RAM contents, different in every word
    function automatic word_t ram_fill(int idx);
        return (word_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    `include "tb_ref_model.svh"

    function automatic word_t rtype_word(logic [5:0] fn, int rd, int rs, int rt, int sh);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, int rt, int rs, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // Outside the program the ROM returns zero, which is a no-op
    function automatic word_t rom_read(word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off < word_t'(PROG_LEN * 4)) begin
            return prog[int'(off >> 2)];
        end
        return '0;
    endfunction

    core_top #(.RESET_PC(RESET_PC)) uut (
        .clk               (clk              ),
        .arst_n_i          (arst_n_i         ),
        .ibus_en_o         (ibus_en_o        ),
        .ibus_addr_o       (ibus_addr_o      ),
        .ibus_rdata_i      (ibus_rdata_i     ),
        .ibus_streq_i      (ibus_streq_i     ),
        .ibus_stall_o      (ibus_stall_o     ),
        .dbus_en_o         (dbus_en_o        ),
        .dbus_addr_o       (dbus_addr_o      ),
        .dbus_wen_o        (dbus_wen_o       ),
        .dbus_wdata_o      (dbus_wdata_o     ),
        .dbus_rdata_i      (dbus_rdata_i     ),
        .dbus_streq_i      (dbus_streq_i     ),
        .dbus_stall_o      (dbus_stall_o     ),
        .debug_wb_pc_o     (debug_wb_pc_o    ),
        .debug_wb_wen_o    (debug_wb_wen_o   ),
        .debug_wb_wraddr_o (debug_wb_wraddr_o),
        .debug_wb_wrdata_o (debug_wb_wrdata_o)
    );

    always #10 clk = ~clk;

    // Both buses answer in the cycle of the request
    assign ibus_rdata_i = rom_read(ibus_addr_o);
    assign dbus_rdata_i = ram[dbus_addr_o[9:2]];

    always @(posedge clk) begin
        if (arst_n_i && dbus_en_o && !dbus_streq_i && dbus_wen_o == 4'hF) begin
            ram[dbus_addr_o[9:2]] <= dbus_wdata_o;
        end
    end

    // Random wait states, both buses drawn in one process so the sequence is fixed
    always @(posedge clk) begin
        if (!arst_n_i || !stalls_on) begin
            ibus_streq_i <= 1'b0;
            dbus_streq_i <= 1'b0;
            istall_left  <= 0;
            dstall_left  <= 0;
        end else begin
            if (istall_left != 0) begin
                istall_left  <= istall_left - 1;
                ibus_streq_i <= 1'b1;
            end else if (($random(seed) & 3) == 0) begin
                ibus_streq_i <= 1'b1;
                istall_left  <= int'($unsigned($random(seed)) % 3);
            end else begin
                ibus_streq_i <= 1'b0;
            end
            if (dstall_left != 0) begin
                dstall_left  <= dstall_left - 1;
                dbus_streq_i <= 1'b1;
            end else if (($random(seed) & 3) == 0) begin
                dbus_streq_i <= 1'b1;
                dstall_left  <= int'($unsigned($random(seed)) % 4);
            end else begin
                dbus_streq_i <= 1'b0;
            end
        end
    end

    // Writeback trace against the reference, in order
    always @(posedge clk) begin : compare_trace
        word_t     e_pc;
        reg_addr_t e_rd;
        word_t     e_val;
        if (arst_n_i && debug_wb_wen_o != '0) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("Register write at pc %h has no matching instruction", debug_wb_pc_o);
            end else begin
                e_pc  = exp_pc.pop_front();
                e_rd  = exp_rd.pop_front();
                e_val = exp_val.pop_front();
                if (debug_wb_wen_o != 4'hF || debug_wb_pc_o != e_pc
                    || debug_wb_wraddr_o != e_rd || debug_wb_wrdata_o != e_val) begin
                    errors++;
                    $display("error %0t: expected pc %h r%0d=%h, got pc %h r%0d=%h wen %b",
                             $time, e_pc, e_rd, e_val, debug_wb_pc_o, debug_wb_wraddr_o,
                             debug_wb_wrdata_o, debug_wb_wen_o);
                end
            end
        end
    end

    // A bus wait holds MEM only for the data bus and always holds IF.
    // IF held with no bus wait is a load-use interlock cycle.
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (dbus_stall_o != dbus_streq_i
                || ((ibus_streq_i || dbus_streq_i) && !ibus_stall_o)) begin
                errors++;
                $display("error %0t: stall outputs i%b d%b for bus requests i%b d%b",
                         $time, ibus_stall_o, dbus_stall_o, ibus_streq_i, dbus_streq_i);
            end
            if (ibus_stall_o && !ibus_streq_i && !dbus_streq_i) begin
                interlocks++;
            end
        end
    end

    always @(posedge clk) begin
        if (cnt_clear) begin
            cycle_cnt <= 0;
        end else if (cycle_cnt >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles, errors: %0d",
                     LIMIT, errors);
            $display("** FAIL **");
            $finish;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic load_program();
        prog[0]  = itype_word(OP_ADDIU, 1, 0, 16'd5);
        prog[1]  = itype_word(OP_ADDIU, 2, 0, 16'hFFFD);
        // Operands from one and two instructions back
        prog[2]  = rtype_word(FN_ADDU, 3, 1, 2, 0);
        prog[3]  = rtype_word(FN_SUBU, 4, 3, 1, 0);
        prog[4]  = rtype_word(FN_AND, 5, 1, 2, 0);
        prog[5]  = rtype_word(FN_OR, 6, 4, 2, 0);
        prog[6]  = rtype_word(FN_XOR, 7, 6, 3, 0);
        prog[7]  = rtype_word(FN_NOR, 8, 7, 1, 0);
        prog[8]  = rtype_word(FN_SLT, 9, 2, 1, 0);
        prog[9]  = rtype_word(FN_SLTU, 10, 2, 1, 0);
        prog[10] = itype_word(OP_SLTI, 11, 2, 16'hFFFF);
        prog[11] = itype_word(OP_ANDI, 12, 2, 16'hF0F0);
        prog[12] = itype_word(OP_ORI, 13, 1, 16'h8000);
        prog[13] = itype_word(OP_XORI, 14, 2, 16'h1234);
        prog[14] = itype_word(OP_LUI, 15, 0, 16'h8765);
        prog[15] = rtype_word(FN_SLL, 16, 0, 15, 4);
        prog[16] = rtype_word(FN_SRL, 17, 0, 15, 28);
        prog[17] = itype_word(OP_ADDIU, 0, 1, 16'd7);
        prog[18] = rtype_word(FN_ADDU, 18, 0, 1, 0);
        prog[19] = itype_word(OP_ADDIU, 20, 0, 16'h0040);
        prog[20] = itype_word(OP_SW, 16, 20, 16'd0);
        prog[21] = itype_word(OP_SW, 17, 20, 16'd4);
        prog[22] = itype_word(OP_LW, 21, 20, 16'd0);
        // Load result used right away
        prog[23] = rtype_word(FN_ADDU, 22, 21, 1, 0);
        prog[24] = itype_word(OP_LW, 23, 20, 16'd4);
        prog[25] = itype_word(OP_SW, 23, 20, 16'd8);
        prog[26] = itype_word(OP_LW, 24, 20, 16'd12);
        prog[27] = rtype_word(FN_ADDU, 25, 24, 24, 0);
        prog[28] = itype_word(OP_SW, 25, 20, 16'd16);
        prog[29] = rtype_word(FN_SUBU, 26, 25, 22, 0);
        prog[30] = 32'hFC00_0000;
        prog[31] = itype_word(OP_ADDIU, 27, 26, 16'd1);
    endtask

    task automatic exercise_core(input logic with_stalls);
        arst_n_i  <= 1'b0;
        stalls_on <= with_stalls;
        cnt_clear <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = ram_fill(i);
        end
        build_expected();
        interlocks = 0;
        repeat (4) @(posedge clk);
        if (ibus_en_o || dbus_en_o || debug_wb_wen_o != '0) begin
            errors++;
            $display("error %0t: bus enable or debug write active in reset", $time);
        end
        arst_n_i  <= 1'b1;
        cnt_clear <= 1'b0;
        @(posedge clk);
        while (!ibus_en_o) begin
            @(posedge clk);
        end
        if (ibus_addr_o != RESET_PC) begin
            errors++;
            $display("error %0t: first fetch at %h, expected %h", $time, ibus_addr_o, RESET_PC);
        end
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
        // Tail of no-ops from the empty ROM
        repeat (10) @(posedge clk);
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (ram[i] != exp_ram[i]) begin
                errors++;
                $display("error %0t: ram word %0d is %h, expected %h",
                         $time, i, ram[i], exp_ram[i]);
            end
        end
        if (!with_stalls && interlocks != exp_interlocks) begin
            errors++;
            $display("error %0t: %0d load-use stall cycles, expected %0d",
                     $time, interlocks, exp_interlocks);
        end
    endtask

    initial begin
        seed         = 32'h75b;
        errors       = 0;
        clk          = 1'b0;
        arst_n_i     <= 1'b0;
        ibus_streq_i <= 1'b0;
        dbus_streq_i <= 1'b0;
        stalls_on    <= 1'b0;
        cnt_clear    <= 1'b1;
        istall_left  <= 0;
        dstall_left  <= 0;
        load_program();
        exercise_core(1'b0);
        exercise_core(1'b1);
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: rtl/core_top.sv
// Five-stage MIPS32 integer core with instruction and data bus ports
// and a writeback debug port for trace comparison.
`timescale 1ns/1ns

module core_top #(
    parameter pipe_pkg::word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic                 clk,
    input  logic                 arst_n_i,

    output logic                 ibus_en_o,
    output pipe_pkg::word_t      ibus_addr_o,
    input  pipe_pkg::word_t      ibus_rdata_i,
    input  logic                 ibus_streq_i,
    output logic                 ibus_stall_o,

    output logic                 dbus_en_o,
    output pipe_pkg::word_t      dbus_addr_o,
    output pipe_pkg::byte_en_t   dbus_wen_o,
    output pipe_pkg::word_t      dbus_wdata_o,
    input  pipe_pkg::word_t      dbus_rdata_i,
    input  logic                 dbus_streq_i,
    output logic                 dbus_stall_o,

    output pipe_pkg::word_t      debug_wb_pc_o,
    output pipe_pkg::byte_en_t   debug_wb_wen_o,
    output pipe_pkg::reg_addr_t  debug_wb_wraddr_o,
    output pipe_pkg::word_t      debug_wb_wrdata_o
);

    import pipe_pkg::*;

    // _d is a stage output, _q the register after it
    if_id_t     if_d;
    if_id_t     id_q;
    id_ex_t     id_d;
    id_ex_t     ex_q;
    ex_mem_t    ex_d;
    ex_mem_t    mem_q;
    mem_wb_t    mem_d;
    mem_wb_t    wb_q;
    stage_vec_t stall;
    stage_vec_t bubble;
    logic       hazard;

    assign ibus_stall_o = stall[IF];
    assign dbus_stall_o = stall[MEM];

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk          (clk         ),
        .arst_n_i     (arst_n_i    ),
        .stall_i      (stall[IF]   ),
        .ibus_en_o    (ibus_en_o   ),
        .ibus_addr_o  (ibus_addr_o ),
        .ibus_rdata_i (ibus_rdata_i),
        .ibus_streq_i (ibus_streq_i),
        .fetch_o      (if_d        )
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk      (clk       ),
        .arst_n_i (arst_n_i  ),
        .stall_i  (stall[ID] ),
        .bubble_i (bubble[ID]),
        .d_i      (if_d      ),
        .q_o      (id_q      )
    );

    decode_stage u_decode (
        .clk       (clk     ),
        .arst_n_i  (arst_n_i),
        .if_id_i   (id_q    ),
        .ex_fwd_i  (ex_d    ),
        .mem_fwd_i (mem_d   ),
        .wb_i      (wb_q    ),
        .id_ex_o   (id_d    ),
        .hazard_o  (hazard  )
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk      (clk       ),
        .arst_n_i (arst_n_i  ),
        .stall_i  (stall[EX] ),
        .bubble_i (bubble[EX]),
        .d_i      (id_d      ),
        .q_o      (ex_q      )
    );

    execute_stage u_execute (
        .id_ex_i  (ex_q),
        .ex_mem_o (ex_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk      (clk        ),
        .arst_n_i (arst_n_i   ),
        .stall_i  (stall[MEM] ),
        .bubble_i (bubble[MEM]),
        .d_i      (ex_d       ),
        .q_o      (mem_q      )
    );

    memory_stage u_memory (
        .ex_mem_i     (mem_q       ),
        .dbus_en_o    (dbus_en_o   ),
        .dbus_addr_o  (dbus_addr_o ),
        .dbus_wen_o   (dbus_wen_o  ),
        .dbus_wdata_o (dbus_wdata_o),
        .dbus_rdata_i (dbus_rdata_i),
        .mem_wb_o     (mem_d       )
    );

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk      (clk       ),
        .arst_n_i (arst_n_i  ),
        .stall_i  (stall[WB] ),
        .bubble_i (bubble[WB]),
        .d_i      (mem_d     ),
        .q_o      (wb_q      )
    );

    pipe_control u_control (
        .ibus_streq_i (ibus_streq_i),
        .dbus_streq_i (dbus_streq_i),
        .hazard_i     (hazard      ),
        .stall_o      (stall       ),
        .bubble_o     (bubble      )
    );

    assign debug_wb_pc_o     = wb_q.pc;
    assign debug_wb_wen_o    = {$bits(byte_en_t){wb_q.valid && wb_q.wen}};
    assign debug_wb_wraddr_o = wb_q.rd;
    assign debug_wb_wrdata_o = wb_q.wdata;

endmodule

// File: rtl/pipe_control.sv
// Central stall unit. Data bus wait beats the load-use hazard,
// which beats an instruction bus wait.
`timescale 1ns/1ns

module pipe_control (
    input  logic                 ibus_streq_i,
    input  logic                 dbus_streq_i,
    input  logic                 hazard_i,
    output pipe_pkg::stage_vec_t stall_o,
    output pipe_pkg::stage_vec_t bubble_o
);

    import pipe_pkg::*;

    always_comb begin
        stall_o  = '0;
        bubble_o = '0;
        if (dbus_streq_i) begin
            stall_o[IF]  = 1'b1;
            stall_o[ID]  = 1'b1;
            stall_o[EX]  = 1'b1;
            stall_o[MEM] = 1'b1;
            bubble_o[WB] = 1'b1;
        end else if (hazard_i) begin
            stall_o[IF]  = 1'b1;
            stall_o[ID]  = 1'b1;
            bubble_o[EX] = 1'b1;
        end else if (ibus_streq_i) begin
            stall_o[IF]  = 1'b1;
            bubble_o[ID] = 1'b1;
        end
    end

endmodule

// File: rtl/memory_stage.sv
// Data bus access for LW and SW, always a full word.
// Picks the writeback value: load data or the ALU result.
`timescale 1ns/1ns

module memory_stage (
    input  pipe_pkg::ex_mem_t  ex_mem_i,
    output logic               dbus_en_o,
    output pipe_pkg::word_t    dbus_addr_o,
    output pipe_pkg::byte_en_t dbus_wen_o,
    output pipe_pkg::word_t    dbus_wdata_o,
    input  pipe_pkg::word_t    dbus_rdata_i,
    output pipe_pkg::mem_wb_t  mem_wb_o
);

    logic store;

    assign store        = ex_mem_i.valid && ex_mem_i.is_store;
    assign dbus_en_o    = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
    assign dbus_addr_o  = ex_mem_i.result;
    assign dbus_wen_o   = {$bits(dbus_wen_o){store}};
    assign dbus_wdata_o = ex_mem_i.store_data;

    always_comb begin
        mem_wb_o.valid = ex_mem_i.valid;
        mem_wb_o.pc    = ex_mem_i.pc;
        mem_wb_o.wen   = ex_mem_i.wen;
        mem_wb_o.rd    = ex_mem_i.rd;
        mem_wb_o.wdata = ex_mem_i.is_load ? dbus_rdata_i : ex_mem_i.result;
        // Word accesses only
        if (dbus_en_o) begin
            assert (dbus_addr_o[1:0] == 2'b00);
        end
    end

endmodule

// File: rtl/execute_stage.sv
// ALU. Loads and stores use the add result as their data address.
`timescale 1ns/1ns

module execute_stage (
    input  pipe_pkg::id_ex_t  id_ex_i,
    output pipe_pkg::ex_mem_t ex_mem_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t opr1;
    word_t opr2;
    word_t result;

    assign opr1 = id_ex_i.opr1;
    assign opr2 = id_ex_i.opr2;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = opr1 + opr2;
            ALU_SUB:  result = opr1 - opr2;
            ALU_AND:  result = opr1 & opr2;
            ALU_OR:   result = opr1 | opr2;
            ALU_XOR:  result = opr1 ^ opr2;
            ALU_NOR:  result = ~(opr1 | opr2);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(opr1) < $signed(opr2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, opr1 < opr2};
            // Shift amount rides in opr1
            ALU_SLL:  result = opr2 << opr1[4:0];
            ALU_SRL:  result = opr2 >> opr1[4:0];
            ALU_LUI:  result = {opr2[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    always_comb begin
        ex_mem_o.valid      = id_ex_i.valid;
        ex_mem_o.pc         = id_ex_i.pc;
        ex_mem_o.result     = result;
        ex_mem_o.store_data = id_ex_i.store_data;
        ex_mem_o.is_load    = id_ex_i.is_load;
        ex_mem_o.is_store   = id_ex_i.is_store;
        ex_mem_o.wen        = id_ex_i.wen;
        ex_mem_o.rd         = id_ex_i.rd;
        if (id_ex_i.valid) begin
            assert (!(id_ex_i.is_load && id_ex_i.is_store));
        end
    end

endmodule

// File: rtl/decode_stage.sv
// Instruction decode with operand forwarding and the load-use check.
// The register file sits here and is written from the WB payload.
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  pipe_pkg::if_id_t  if_id_i,
    input  pipe_pkg::ex_mem_t ex_fwd_i,
    input  pipe_pkg::mem_wb_t mem_fwd_i,
    input  pipe_pkg::mem_wb_t wb_i,
    output pipe_pkg::id_ex_t  id_ex_o,
    output logic              hazard_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0]      opcode;
    logic [5:0]      funct;
    reg_addr_t       rs;
    reg_addr_t       rt;
    reg_addr_t       rd;
    reg_addr_t       dest;
    logic [4:0]      shamt;
    logic [IMM_W-1:0] imm;
    word_t           imm_ext;
    word_t           rf_rs;
    word_t           rf_rt;
    word_t           rs_val;
    word_t           rt_val;
    alu_op_t         alu_op;
    logic            known;
    logic            is_rtype;
    logic            is_shift;
    logic            sext_imm;
    logic            use_rs;
    logic            use_rt;

    // Youngest producer wins
    function automatic word_t forward(reg_addr_t addr, word_t rf_val);
        if (ex_fwd_i.valid && ex_fwd_i.wen && ex_fwd_i.rd == addr) begin
            return ex_fwd_i.result;
        end
        if (mem_fwd_i.valid && mem_fwd_i.wen && mem_fwd_i.rd == addr) begin
            return mem_fwd_i.wdata;
        end
        return rf_val;
    endfunction

    reg_file u_reg_file (
        .clk       (clk     ),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs      ),
        .rt_addr_i (rt      ),
        .rs_data_o (rf_rs   ),
        .rt_data_o (rf_rt   ),
        .wb_i      (wb_i    )
    );

    assign opcode = if_id_i.inst[OP_LSB +: 6];
    assign funct  = if_id_i.inst[FUNCT_LSB +: 6];
    assign rs     = if_id_i.inst[RS_LSB +: 5];
    assign rt     = if_id_i.inst[RT_LSB +: 5];
    assign rd     = if_id_i.inst[RD_LSB +: 5];
    assign shamt  = if_id_i.inst[SHAMT_LSB +: 5];
    assign imm    = if_id_i.inst[IMM_LSB +: IMM_W];

    always_comb begin
        alu_op = ALU_ADD;
        known  = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: alu_op = ALU_ADD;
            OP_SLTI: alu_op = ALU_SLT;
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: known = 1'b0;
        endcase
    end

    assign is_rtype = (opcode == OP_SPECIAL);
    assign is_shift = is_rtype && (funct == FN_SLL || funct == FN_SRL);
    assign sext_imm = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
    assign imm_ext  = {{(XLEN-IMM_W){sext_imm && imm[IMM_W-1]}}, imm};
    assign dest     = is_rtype ? rd : rt;

    // Shifts take shamt in place of rs, LUI reads no register
    assign use_rs = known && !is_shift && (opcode != OP_LUI);
    assign use_rt = known && (is_rtype || opcode == OP_SW);

    always_comb begin
        rs_val = forward(rs, rf_rs);
        rt_val = forward(rt, rf_rt);
    end

    always_comb begin
        id_ex_o.valid      = if_id_i.valid;
        id_ex_o.pc         = if_id_i.pc;
        id_ex_o.alu_op     = alu_op;
        id_ex_o.opr1       = is_shift ? {{(XLEN-5){1'b0}}, shamt} : rs_val;
        id_ex_o.opr2       = is_rtype ? rt_val : imm_ext;
        id_ex_o.store_data = rt_val;
        id_ex_o.is_load    = known && (opcode == OP_LW);
        id_ex_o.is_store   = known && (opcode == OP_SW);
        id_ex_o.wen        = known && (opcode != OP_SW) && (dest != '0);
        id_ex_o.rd         = dest;
    end

    // A load in EX has no data yet, so a reader behind it must wait a cycle
    assign hazard_o = if_id_i.valid && ex_fwd_i.valid && ex_fwd_i.is_load && ex_fwd_i.wen
                      && ((use_rs && ex_fwd_i.rd == rs) || (use_rt && ex_fwd_i.rd == rt));

endmodule

// File: rtl/reg_file.sv
// General purpose registers: two read ports, one write port from writeback.
// A read of the register being written returns the new value.
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  pipe_pkg::reg_addr_t rs_addr_i,
    input  pipe_pkg::reg_addr_t rt_addr_i,
    output pipe_pkg::word_t     rs_data_o,
    output pipe_pkg::word_t     rt_data_o,
    input  pipe_pkg::mem_wb_t   wb_i
);

    import pipe_pkg::*;

    word_t regs [32];
    logic  wr_en;

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && addr == wb_i.rd) begin
            return wb_i.wdata;
        end
        return regs[addr];
    endfunction

    assign wr_en = wb_i.valid && wb_i.wen && (wb_i.rd != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

// File: rtl/fetch_stage.sv
// Program counter and instruction bus request.
// The PC moves on only when a fetch completes and IF is not held.
`timescale 1ns/1ns

module fetch_stage #(
    parameter pipe_pkg::word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    output logic             ibus_en_o,
    output pipe_pkg::word_t  ibus_addr_o,
    input  pipe_pkg::word_t  ibus_rdata_i,
    input  logic             ibus_streq_i,
    output pipe_pkg::if_id_t fetch_o
);

    import pipe_pkg::*;

    word_t pc;
    logic  fetch_on;
    logic  fetch_done;

    assign fetch_done = ibus_en_o && !ibus_streq_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc       <= RESET_PC;
            fetch_on <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (fetch_done && !stall_i) begin
                pc <= pc + word_t'(4);
            end
        end
    end

    assign ibus_en_o     = fetch_on;
    assign ibus_addr_o   = pc;
    assign fetch_o.valid = fetch_done;
    assign fetch_o.pc    = pc;
    assign fetch_o.inst  = ibus_rdata_i;

endmodule

// File: rtl/stage_reg.sv
// Register between two pipeline stages, one instance per payload struct.
// Holds on stall. A bubble loads an all-zero payload, which leaves valid clear.
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (bubble_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    // Control never asks one register to hold and to flush in the same cycle
    a_no_stall_and_bubble: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(stall_i && bubble_i)
    );

endmodule

// File: rtl/pipe_pkg.sv
// Datapath widths, the payload carried between stages and the stall vector type.
// Ports name these types by scope. Module bodies import the package.
package pipe_pkg;

    localparam int XLEN    = 32;
    localparam int NSTAGES = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [XLEN/8-1:0] byte_en_t;

    // Index into the stall and bubble vectors
    typedef enum logic [2:0] {IF, ID, EX, MEM, WB} stage_e;

    typedef logic [NSTAGES-1:0] stage_vec_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        word_t             pc;
        isa_pkg::alu_op_t  alu_op;
        word_t             opr1;
        word_t             opr2;
        word_t             store_data;
        logic              is_load;
        logic              is_store;
        logic              wen;
        reg_addr_t         rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        word_t     store_data;
        logic      is_load;
        logic      is_store;
        logic      wen;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wen;
        reg_addr_t rd;
        word_t     wdata;
    } mem_wb_t;

endpackage

// File: rtl/isa_pkg.sv
// MIPS32 encodings for the integer subset run by the core.
// Decode and execute import it.
package isa_pkg;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0A;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // Funct codes under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    // Field positions in the instruction word
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_LSB   = 0;
    localparam int IMM_W     = 16;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

endpackage
